/* cd_route_pkg.sv */
// Shared sizes and types for the CD ordering and routing block
package cd_route_pkg;

    // Snoop port sizing
    localparam int unsigned NumSnoopPorts = 4;
    localparam int unsigned PortIdxBits   = $clog2(NumSnoopPorts);
    localparam int unsigned CdDataWidth   = 64;

    // Outstanding write-back records
    localparam int unsigned OrderDepth    = 4;
    localparam int unsigned OrderPtrBits  = $clog2(OrderDepth);
    localparam int unsigned OrderCntBits  = $clog2(OrderDepth + 1);

    typedef enum logic {
        MEMORY_UNIT,
        SNOOP_UNIT
    } cd_user_e;

    typedef logic [PortIdxBits-1:0]   port_idx_t;
    typedef logic [NumSnoopPorts-1:0] port_mask_t;
    typedef logic [CdDataWidth-1:0]   cd_data_t;

    // One recorded snoop expecting write-back data
    typedef struct packed {
        cd_user_e   user;
        port_idx_t  first_responder;
        port_mask_t data_available;
    } order_entry_t;

endpackage

/* cd_order_queue.sv */
// CD order queue
// Records write-back issue events in issue order and presents the oldest
// record; an empty queue passes an incoming record straight to the head
module cd_order_queue (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       mu_push_i,
    input  logic                       su_push_i,
    input  cd_route_pkg::port_idx_t    first_responder_i,
    input  cd_route_pkg::port_mask_t   data_available_i,
    input  logic                       retire_i,
    output logic                       stall_o,
    output logic                       head_valid_o,
    output cd_route_pkg::order_entry_t head_entry_o
);

    import cd_route_pkg::*;

    order_entry_t              entry_in;
    order_entry_t              mem_q [OrderDepth];
    logic [OrderPtrBits-1:0]   rd_ptr_q;
    logic [OrderPtrBits-1:0]   wr_ptr_q;
    logic [OrderCntBits-1:0]   count_q;
    logic                      push;
    logic                      empty;
    logic                      do_push;
    logic                      do_pop;

    //////////////////////////////////////////////////////////////////////
    // Entry build
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        entry_in.user            = mu_push_i ? MEMORY_UNIT : SNOOP_UNIT;
        entry_in.first_responder = first_responder_i;
        entry_in.data_available  = data_available_i;
    end

    assign push  = mu_push_i | su_push_i;
    assign empty = (count_q == '0);

    // Record retired in its own push cycle never enters the buffer
    assign do_push = push && !(empty && retire_i);
    assign do_pop  = retire_i && !empty;

    assign stall_o      = (count_q == OrderCntBits'(OrderDepth));
    assign head_valid_o = !empty || push;
    assign head_entry_o = empty ? entry_in : mem_q[rd_ptr_q];

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_in;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* cd_beat_tracker.sv */
// CD beat tracker
// Flags each masked port's accepted last beat, drives the per-port ready
// and retires the head record once every masked port has finished
module cd_beat_tracker (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       head_valid_i,
    input  cd_route_pkg::order_entry_t head_entry_i,
    input  logic                       owner_full_i,
    input  cd_route_pkg::port_mask_t   cd_valid_i,
    input  cd_route_pkg::port_mask_t   cd_last_i,
    output cd_route_pkg::port_mask_t   cd_ready_o,
    output logic                       retire_o
);

    import cd_route_pkg::*;

    port_mask_t last_q;
    port_mask_t last_d;
    port_mask_t accepted;

    // Ready per port
    always_comb begin
        for (int i = 0; i < NumSnoopPorts; i++) begin
            cd_ready_o[i] = head_valid_i
                         && head_entry_i.data_available[i]
                         && !last_q[i]
                         && !(owner_full_i
                              && (head_entry_i.first_responder == port_idx_t'(i)));
        end
    end

    assign accepted = cd_valid_i & cd_ready_o;

    // All masked ports done
    assign retire_o = head_valid_i && (last_q == head_entry_i.data_available);

    always_comb begin
        if (retire_o) begin
            last_d = '0;
        end else begin
            last_d = last_q | (accepted & cd_last_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
        end else begin
            last_q <= last_d;
        end
    end

endmodule

/* cd_steer.sv */
// CD steering
// Forwards the first responder's beats to the unit owning the head record
module cd_steer (
    input  logic                                                   head_valid_i,
    input  cd_route_pkg::order_entry_t                             head_entry_i,
    input  cd_route_pkg::port_mask_t                               cd_valid_i,
    input  cd_route_pkg::port_mask_t                               cd_ready_i,
    input  cd_route_pkg::port_mask_t                               cd_last_i,
    input  cd_route_pkg::cd_data_t [cd_route_pkg::NumSnoopPorts-1:0] cd_data_i,
    input  logic                                                   mu_full_i,
    input  logic                                                   su_full_i,
    output logic                                                   owner_full_o,
    output logic                                                   mu_cd_valid_o,
    output logic                                                   su_cd_valid_o,
    output logic                                                   mu_cd_last_o,
    output logic                                                   su_cd_last_o,
    output cd_route_pkg::cd_data_t                                 mu_cd_data_o,
    output cd_route_pkg::cd_data_t                                 su_cd_data_o
);

    import cd_route_pkg::*;

    port_idx_t first;
    cd_data_t  sel_data;
    logic      sel_last;
    logic      handshake;

    assign first     = head_entry_i.first_responder;
    assign sel_data  = cd_data_i[first];
    assign sel_last  = cd_last_i[first];
    assign handshake = head_valid_i && cd_valid_i[first] && cd_ready_i[first];

    // Both owners see the same beat, only the valid is steered
    assign mu_cd_data_o = sel_data;
    assign su_cd_data_o = sel_data;
    assign mu_cd_last_o = sel_last;
    assign su_cd_last_o = sel_last;

    always_comb begin
        mu_cd_valid_o = 1'b0;
        su_cd_valid_o = 1'b0;
        owner_full_o  = 1'b0;
        if (head_valid_i) begin
            case (head_entry_i.user)
                MEMORY_UNIT: begin
                    mu_cd_valid_o = handshake;
                    owner_full_o  = mu_full_i;
                end
                SNOOP_UNIT: begin
                    su_cd_valid_o = handshake;
                    owner_full_o  = su_full_i;
                end
                default: begin
                    owner_full_o  = 1'b0;
                end
            endcase
        end
    end

endmodule

/* cd_router.sv */
// CD router top level
// Orders write-back records and routes snoop data beats to their owners
module cd_router (
    input  logic                                                   clk_i,
    input  logic                                                   rst_ni,
    // Issue side
    input  logic                                                   mu_push_i,
    input  logic                                                   su_push_i,
    input  cd_route_pkg::port_idx_t                                first_responder_i,
    input  cd_route_pkg::port_mask_t                               data_available_i,
    output logic                                                   stall_o,
    // Snoop side
    input  cd_route_pkg::port_mask_t                               cd_valid_i,
    input  cd_route_pkg::cd_data_t [cd_route_pkg::NumSnoopPorts-1:0] cd_data_i,
    input  cd_route_pkg::port_mask_t                               cd_last_i,
    output cd_route_pkg::port_mask_t                               cd_ready_o,
    // Owner side
    output logic                                                   mu_cd_valid_o,
    output cd_route_pkg::cd_data_t                                 mu_cd_data_o,
    output logic                                                   mu_cd_last_o,
    output logic                                                   su_cd_valid_o,
    output cd_route_pkg::cd_data_t                                 su_cd_data_o,
    output logic                                                   su_cd_last_o,
    input  logic                                                   mu_full_i,
    input  logic                                                   su_full_i
);

    import cd_route_pkg::*;

    logic         head_valid;
    order_entry_t head_entry;
    logic         retire;
    logic         owner_full;

    cd_order_queue i_cd_order_queue (
        .clk_i,
        .rst_ni,
        .mu_push_i,
        .su_push_i,
        .first_responder_i,
        .data_available_i,
        .retire_i          (retire),
        .stall_o,
        .head_valid_o      (head_valid),
        .head_entry_o      (head_entry)
    );

    cd_beat_tracker i_cd_beat_tracker (
        .clk_i,
        .rst_ni,
        .head_valid_i (head_valid),
        .head_entry_i (head_entry),
        .owner_full_i (owner_full),
        .cd_valid_i,
        .cd_last_i,
        .cd_ready_o,
        .retire_o     (retire)
    );

    cd_steer i_cd_steer (
        .head_valid_i  (head_valid),
        .head_entry_i  (head_entry),
        .cd_valid_i,
        .cd_ready_i    (cd_ready_o),
        .cd_last_i,
        .cd_data_i,
        .mu_full_i,
        .su_full_i,
        .owner_full_o  (owner_full),
        .mu_cd_valid_o,
        .su_cd_valid_o,
        .mu_cd_last_o,
        .su_cd_last_o,
        .mu_cd_data_o,
        .su_cd_data_o
    );

endmodule

/* cd_router_assert.sv */
// Protocol checks bound into the CD router
module cd_router_assert (
    input logic                       clk_i,
    input logic                       rst_ni,
    input logic                       mu_push_i,
    input logic                       su_push_i,
    input cd_route_pkg::port_mask_t   data_available_i,
    input logic                       stall_i,
    input cd_route_pkg::port_mask_t   cd_valid_i,
    input cd_route_pkg::port_mask_t   cd_last_i,
    input cd_route_pkg::port_mask_t   cd_ready_i,
    input logic                       mu_cd_valid_i,
    input logic                       mu_cd_last_i,
    input logic                       su_cd_valid_i,
    input logic                       su_cd_last_i
);

    import cd_route_pkg::*;

    logic [OrderCntBits-1:0] port_open_q [NumSnoopPorts];
    logic [OrderCntBits-1:0] mu_open_q;
    logic [OrderCntBits-1:0] su_open_q;
    port_mask_t              open_mask;
    logic                    push;

    assign push = mu_push_i | su_push_i;

    // Records still owed data, counted from the issue side
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mu_open_q <= '0;
            su_open_q <= '0;
            for (int i = 0; i < NumSnoopPorts; i++) begin
                port_open_q[i] <= '0;
            end
        end else begin
            mu_open_q <= mu_open_q + OrderCntBits'(mu_push_i)
                       - OrderCntBits'(mu_cd_valid_i && mu_cd_last_i);
            su_open_q <= su_open_q + OrderCntBits'(su_push_i)
                       - OrderCntBits'(su_cd_valid_i && su_cd_last_i);
            for (int i = 0; i < NumSnoopPorts; i++) begin
                port_open_q[i] <= port_open_q[i]
                                + OrderCntBits'(push && data_available_i[i])
                                - OrderCntBits'(cd_valid_i[i] && cd_ready_i[i] && cd_last_i[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NumSnoopPorts; i++) begin
            open_mask[i] = (port_open_q[i] != '0) || (push && data_available_i[i]);
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) !(mu_push_i && su_push_i))
        else $error("both push strobes high");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     !((mu_push_i || su_push_i) && stall_i))
        else $error("push while stalled");

    // Each owner valid goes alone to an owner with a record outstanding
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     mu_cd_valid_i |-> !su_cd_valid_i && (mu_open_q != '0 || mu_push_i))
        else $error("memory unit valid without its record");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     su_cd_valid_i |-> (su_open_q != '0 || su_push_i))
        else $error("snoop unit valid without its record");

    // Ready only on ports that an outstanding record still expects data from
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     (cd_ready_i & ~open_mask) == '0)
        else $error("ready on unmasked port");

endmodule

bind cd_router cd_router_assert i_cd_router_assert (
    .clk_i,
    .rst_ni,
    .mu_push_i,
    .su_push_i,
    .data_available_i,
    .stall_i          (stall_o),
    .cd_valid_i,
    .cd_last_i,
    .cd_ready_i       (cd_ready_o),
    .mu_cd_valid_i    (mu_cd_valid_o),
    .mu_cd_last_i     (mu_cd_last_o),
    .su_cd_valid_i    (su_cd_valid_o),
    .su_cd_last_i     (su_cd_last_o)
);

/* tb_cd_router.sv */
// Testbench for the CD router
// Records come from a data file; beats, gaps and full levels are randomized
module tb_cd_router;

    import cd_route_pkg::*;

    logic                            clk_i;
    logic                            rst_ni;
    logic                            mu_push_i;
    logic                            su_push_i;
    port_idx_t                       first_responder_i;
    port_mask_t                      data_available_i;
    logic                            stall_o;
    port_mask_t                      cd_valid_i;
    cd_data_t [NumSnoopPorts-1:0]    cd_data_i;
    port_mask_t                      cd_last_i;
    port_mask_t                      cd_ready_o;
    logic                            mu_cd_valid_o;
    cd_data_t                        mu_cd_data_o;
    logic                            mu_cd_last_o;
    logic                            su_cd_valid_o;
    cd_data_t                        su_cd_data_o;
    logic                            su_cd_last_o;
    logic                            mu_full_i;
    logic                            su_full_i;

    // Records and beat streams
    logic       rec_owner [$];
    port_idx_t  rec_resp [$];
    port_mask_t rec_mask [$];
    cd_data_t   beat_data [NumSnoopPorts][$];
    logic       beat_last [NumSnoopPorts][$];
    cd_data_t   exp_data [$];
    logic       exp_last [$];
    logic       exp_owner [$];

    logic [31:0] rng;
    int          rec_idx;
    int          fwd_idx;
    int          total_beats;
    int          limit;
    int          cycles;
    port_mask_t  accepted;
    logic        stall_seen;

    // Head record as expected from the ordering rules
    int          head_idx;
    port_mask_t  model_last;
    logic        model_retire;
    logic        head_full;
    port_mask_t  exp_ready;

    cd_router i_cd_router (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Compare tasks
    ///////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input cd_data_t exp, input cd_data_t act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_ready(input string name, input port_mask_t exp,
                               input port_mask_t act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Expands each record into per-port beats and the forwarded sequence
    task automatic load_records();
        int         fd;
        int         n;
        string      line;
        logic [7:0] own;
        logic [7:0] resp;
        logic [7:0] mask;
        int         nb;
        cd_data_t   base;
        fd = $fopen("cd_router_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("Test FAILED");
            $fatal(1, "missing stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = 0;
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", own, resp, mask, nb, base);
            end
            if (n == 5) begin
                rec_owner.push_back(own[0]);
                rec_resp.push_back(port_idx_t'(resp));
                rec_mask.push_back(port_mask_t'(mask));
                for (int p = 0; p < NumSnoopPorts; p++) begin
                    for (int k = 1; k <= nb && mask[p]; k++) begin
                        beat_data[p].push_back(base + cd_data_t'(16 * p + k));
                        beat_last[p].push_back(k == nb);
                        total_beats++;
                        if (p == int'(resp)) begin
                            exp_data.push_back(base + cd_data_t'(16 * p + k));
                            exp_last.push_back(k == nb);
                            exp_owner.push_back(own[0]);
                        end
                    end
                end
            end
        end
        $fclose(fd);
        limit = 8 * total_beats + 200;
    endtask

    function automatic logic beats_pending();
        for (int p = 0; p < NumSnoopPorts; p++) begin
            if (beat_data[p].size() > 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycles++;
            if (limit > 0 && cycles >= limit) begin
                $display("Timeout after %0d cycles, %0d of %0d beats forwarded",
                         cycles, fwd_idx, exp_data.size());
                $display("Test FAILED");
                $fatal(1, "run did not complete");
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // One cycle: drive at the falling edge, sample before the rising edge
    ///////////////////////////////////////////////////////////////////////

    task automatic step();
        @(negedge clk_i);
        for (int p = 0; p < NumSnoopPorts; p++) begin
            if (accepted[p]) begin
                model_last[p] = model_last[p] | beat_last[p][0];
                void'(beat_data[p].pop_front());
                void'(beat_last[p].pop_front());
            end
        end
        // Head leaves the queue at the end of its retire cycle
        if (model_retire) begin
            head_idx++;
            model_last = '0;
        end
        check_bit("stall", (rec_idx - head_idx) == OrderDepth, stall_o);
        mu_push_i = 1'b0;
        su_push_i = 1'b0;
        if (rec_idx < rec_owner.size() && !stall_o) begin
            mu_push_i         = (rec_owner[rec_idx] == 1'b0);
            su_push_i         = (rec_owner[rec_idx] == 1'b1);
            first_responder_i = rec_resp[rec_idx];
            data_available_i  = rec_mask[rec_idx];
            rec_idx++;
        end
        for (int p = 0; p < NumSnoopPorts; p++) begin
            rng = xorshift32(rng);
            cd_valid_i[p] = (beat_data[p].size() > 0) && (rng[1:0] != 2'd0);
            cd_data_i[p]  = (beat_data[p].size() > 0) ? beat_data[p][0] : '0;
            cd_last_i[p]  = (beat_last[p].size() > 0) ? beat_last[p][0] : 1'b0;
        end
        rng = xorshift32(rng);
        mu_full_i = (rng[3:2] == 2'd0);
        su_full_i = (rng[5:4] == 2'd0);
        #40;
        exp_ready = '0;
        if (head_idx < rec_idx) begin
            head_full = rec_owner[head_idx] ? su_full_i : mu_full_i;
            for (int p = 0; p < NumSnoopPorts; p++) begin
                exp_ready[p] = rec_mask[head_idx][p] && !model_last[p]
                            && !(head_full && p == int'(rec_resp[head_idx]));
            end
        end
        check_ready("ready", exp_ready, cd_ready_o);
        model_retire = (head_idx < rec_idx) && (model_last == rec_mask[head_idx]);
        accepted = cd_valid_i & cd_ready_o;
        stall_seen |= stall_o;
        check_bit("forward to full memory unit", 1'b0, mu_cd_valid_o & mu_full_i);
        check_bit("forward to full snoop unit", 1'b0, su_cd_valid_o & su_full_i);
        if (mu_cd_valid_o || su_cd_valid_o) begin
            if (fwd_idx >= exp_data.size()) begin
                $display("A beat was forwarded after all expected beats");
                $display("Test FAILED");
                $fatal(1, "extra beat");
            end
            check_bit("owner", exp_owner[fwd_idx], su_cd_valid_o);
            check_data("data", exp_data[fwd_idx],
                       su_cd_valid_o ? su_cd_data_o : mu_cd_data_o);
            check_bit("last", exp_last[fwd_idx],
                      su_cd_valid_o ? su_cd_last_o : mu_cd_last_o);
            fwd_idx++;
        end
    endtask

    initial begin
        rst_ni            = 1'b0;
        mu_push_i         = 1'b0;
        su_push_i         = 1'b0;
        first_responder_i = '0;
        data_available_i  = '0;
        cd_valid_i        = '0;
        cd_data_i         = '0;
        cd_last_i         = '0;
        mu_full_i         = 1'b0;
        su_full_i         = 1'b0;
        rng               = 32'had6c;
        accepted          = '0;
        stall_seen        = 1'b0;
        head_idx          = 0;
        model_last        = '0;
        model_retire      = 1'b0;
        head_full         = 1'b0;
        exp_ready         = '0;
        load_records();
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        #10;
        check_ready("ready after reset", '0, cd_ready_o);
        check_bit("mu valid after reset", 1'b0, mu_cd_valid_o);
        check_bit("su valid after reset", 1'b0, su_cd_valid_o);
        check_bit("stall after reset", 1'b0, stall_o);
        while (rec_idx < rec_owner.size() || beats_pending()) begin
            step();
        end
        repeat (3) step();
        check_bit("all beats forwarded", 1'b1, fwd_idx == exp_data.size());
        check_bit("stall seen", 1'b1, stall_seen);
        check_bit("stall at end", 1'b0, stall_o);
        check_ready("ready at end", '0, cd_ready_o);
        $display("Test OK");
        $finish;
    end

endmodule

/* cd_router_testdata.txt */
# owner(0 memory unit, 1 snoop unit) responder mask beats base, all hex
# every masked port sends the beat count; beat k of port p is base + 16*p + k
0 0 1 4 1000
1 2 e 3 2000
0 1 3 2 3000
1 3 8 5 4000
0 2 f 1 5000
1 0 5 3 6000
0 3 c 2 7000
1 1 a 4 8000

/* build.f */
cd_route_pkg.sv
cd_order_queue.sv
cd_beat_tracker.sv
cd_steer.sv
cd_router.sv
cd_router_assert.sv
tb_cd_router.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cd_router
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^Test OK$$'

clean:
	rm -rf $(OBJ_DIR)
